//--- Makefile
VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
FILE_LIST  := list.f
RTL_TOP    := switch_top
TB_TOP     := switch_tb
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o $(TB_TOP)
	-./$(BUILD_DIR)/$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/output_queues.sv
`default_nettype none

`include "switch_config.svh"

module output_queues (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  switch_pkg::wr_desc_t  [`SW_NUM_PORTS-1:0]     desc,
    input  logic                  [`SW_NUM_PORTS-1:0]     desc_valid,
    output logic                  [`SW_NUM_PORTS-1:0]     grant,
    input  logic                  [`SW_NUM_PORTS-1:0]     queue_pop,
    output switch_pkg::pkt_desc_t [`SW_NUM_PORTS-1:0]     queue_head,
    output logic                  [`SW_NUM_PORTS-1:0]     queue_valid
);
    import switch_pkg::*;

    localparam int N = `SW_NUM_PORTS;

    port_id_t  rr_ptr;
    port_id_t  win;
    logic      any_req;
    pkt_desc_t push_desc;
    logic      [N-1:0] push;

    // ======================================================================
    // round-robin arbiter over pending descriptors
    // ======================================================================
    always_comb begin
        port_id_t idx;
        win     = rr_ptr;
        any_req = 1'b0;
        for (int i = 0; i < N; i++) begin
            idx = rr_ptr + port_id_t'(i);  // search starts at the pointer and wraps
            if (!any_req && desc_valid[idx]) begin
                win     = idx;
                any_req = 1'b1;
            end
        end
        grant      = '0;
        grant[win] = any_req;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (any_req) begin
            rr_ptr <= win + 1'b1;  // next search begins after the granted port
        end
    end

    // the bank is the index of the winning write port
    assign push_desc = '{
        bank: win,
        page: desc[win].page,
        dest: desc[win].dest,
        len:  desc[win].len
    };

    // ======================================================================
    // one queue per output
    // ======================================================================
    for (genvar q = 0; q < N; q++) begin : g_queue
        assign push[q] = any_req && (desc[win].dest == port_id_t'(q));

        sync_fifo #(
            .T     (pkt_desc_t),
            .DEPTH (`SW_QUEUE_DEPTH)
        ) queue_inst (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (push[q]),
            .push_data (push_desc),
            .pop       (queue_pop[q]),
            .head      (queue_head[q]),
            .not_empty (queue_valid[q])
        );
    end

endmodule

`default_nettype wire

//--- hw/packet_bank.sv
`default_nettype none

`include "switch_config.svh"

module packet_bank (
    input  logic                 clk,
    input  logic                 rst_n,
    input  switch_pkg::bank_wr_t wr,
    input  logic                 alloc,
    output switch_pkg::page_id_t free_page,
    output logic                 free_valid,
    input  switch_pkg::bank_rd_t rd_addr,
    output switch_pkg::data_t    rd_data,
    input  logic                 release_en,
    input  switch_pkg::page_id_t release_page
);
    import switch_pkg::*;

    localparam int PAGES = `SW_PAGES_PER_BANK;
    localparam int WORDS = `SW_PAGES_PER_BANK * `SW_PAGE_WORDS;
    localparam int FW    = $clog2(PAGES) + 1;
    localparam logic [FW-1:0] FILL_DONE = FW'(PAGES);

    data_t          mem [WORDS];
    logic [FW-1:0]  fill_cnt;
    logic           filling;
    logic           fl_push;
    page_id_t       fl_data;

    // ======================================================================
    // page memory
    // ======================================================================
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[{wr.page, wr.word}] <= wr.data;
        end
        rd_data <= mem[{rd_addr.page, rd_addr.word}];  // data is valid one cycle after address
    end

    // ======================================================================
    // free-page list
    // ======================================================================
    assign filling = (fill_cnt != FILL_DONE);
    assign fl_push = filling || release_en;
    // no page is out while the list fills, so a release cannot collide with it
    assign fl_data = filling ? page_id_t'(fill_cnt) : release_page;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_cnt <= '0;
        end else if (filling) begin
            fill_cnt <= fill_cnt + 1'b1;  // one page enters the list per cycle
        end
    end

    sync_fifo #(
        .T     (page_id_t),
        .DEPTH (PAGES)
    ) free_list_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (fl_push),
        .push_data (fl_data),
        .pop       (alloc),
        .head      (free_page),
        .not_empty (free_valid)
    );

endmodule

`default_nettype wire

//--- hw/read_scheduler.sv
`default_nettype none

`include "switch_config.svh"

module read_scheduler (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  switch_pkg::pkt_desc_t [`SW_NUM_PORTS-1:0] queue_head,
    input  logic                  [`SW_NUM_PORTS-1:0] queue_valid,
    input  logic                  [`SW_NUM_PORTS-1:0] ready,
    output logic                  [`SW_NUM_PORTS-1:0] queue_pop,
    output switch_pkg::bank_rd_t                      bank_rd,
    input  switch_pkg::data_t     [`SW_NUM_PORTS-1:0] bank_rd_data,
    output logic                  [`SW_NUM_PORTS-1:0] release_en,
    output switch_pkg::page_id_t                      release_page,
    output switch_pkg::rd_beat_t  [`SW_NUM_PORTS-1:0] rd
);
    import switch_pkg::*;

    localparam int N = `SW_NUM_PORTS;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        SEND
    } state_t;

    state_t    state;
    port_id_t  rr_ptr;
    port_id_t  pick;
    logic      found;
    pkt_desc_t cur;       // packet in service
    pkt_len_t  addr_cnt;  // read address, one word ahead of the beat on the output
    logic      sending;
    logic      last;
    data_t     sel_data;

    // ======================================================================
    // output pick
    // ======================================================================
    always_comb begin
        port_id_t idx;
        pick  = rr_ptr;
        found = 1'b0;
        for (int i = 0; i < N; i++) begin
            idx = rr_ptr + port_id_t'(i);
            // ready counts only here, a started packet runs to its end
            if (!found && queue_valid[idx] && ready[idx]) begin
                pick  = idx;
                found = 1'b1;
            end
        end
        queue_pop       = '0;
        queue_pop[pick] = (state == IDLE) && found;
    end

    // ======================================================================
    // fetch pipeline and output beats
    // ======================================================================
    assign sending  = (state == SEND);
    assign last     = sending && (addr_cnt == cur.len);  // beat index is addr_cnt - 1
    assign sel_data = bank_rd_data[cur.bank];
    assign bank_rd  = '{page: cur.page, word: word_idx_t'(addr_cnt)};

    assign release_page = cur.page;

    always_comb begin
        release_en           = '0;
        release_en[cur.bank] = last;  // the page goes back in the eop cycle
    end

    always_comb begin
        for (int p = 0; p < N; p++) begin
            rd[p].vld  = sending && (cur.dest == port_id_t'(p));
            rd[p].sop  = rd[p].vld && (addr_cnt == pkt_len_t'(1));
            rd[p].eop  = rd[p].vld && last;
            rd[p].data = rd[p].vld ? sel_data : '0;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == IDLE) && found) begin
            cur <= queue_head[pick];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            rr_ptr   <= '0;
            addr_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (found) begin
                        rr_ptr   <= pick + 1'b1;
                        addr_cnt <= '0;
                        state    <= FETCH;
                    end
                end
                FETCH: begin
                    addr_cnt <= addr_cnt + 1'b1;  // word 0 is addressed here
                    state    <= SEND;
                end
                SEND: begin
                    addr_cnt <= addr_cnt + 1'b1;
                    if (last) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/switch_pkg.sv
`default_nettype none

`include "switch_config.svh"

package switch_pkg;

    // ======================================================================
    // scalar types
    // ======================================================================
    typedef logic [$clog2(`SW_NUM_PORTS)-1:0]      port_id_t;
    typedef logic [`SW_DATA_WIDTH-1:0]             data_t;
    typedef logic [$clog2(`SW_PAGES_PER_BANK)-1:0] page_id_t;
    typedef logic [$clog2(`SW_PAGE_WORDS)-1:0]     word_idx_t;
    typedef logic [$clog2(`SW_PAGE_WORDS):0]       pkt_len_t;   // 1 to 16 needs one bit more

    // ======================================================================
    // beats on the external ports
    // ======================================================================
    typedef struct packed {
        logic  sop;
        logic  eop;
        logic  vld;
        data_t data;
    } wr_beat_t;

    typedef struct packed {
        logic  sop;
        logic  eop;
        logic  vld;
        data_t data;
    } rd_beat_t;

    // ======================================================================
    // bank access and descriptors
    // ======================================================================
    typedef struct packed {
        logic      en;
        page_id_t  page;
        word_idx_t word;
        data_t     data;
    } bank_wr_t;

    typedef struct packed {
        page_id_t  page;
        word_idx_t word;
    } bank_rd_t;

    typedef struct packed {
        page_id_t page;
        port_id_t dest;
        pkt_len_t len;
    } wr_desc_t;

    typedef struct packed {
        port_id_t bank;  // bank number equals the input port that wrote it
        page_id_t page;
        port_id_t dest;
        pkt_len_t len;
    } pkt_desc_t;

endpackage

`default_nettype wire

//--- hw/switch_top.sv
`default_nettype none

`include "switch_config.svh"

module switch_top (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  switch_pkg::wr_beat_t [`SW_NUM_PORTS-1:0] wr,
    output logic                 [`SW_NUM_PORTS-1:0] pause,
    input  logic                 [`SW_NUM_PORTS-1:0] ready,
    output switch_pkg::rd_beat_t [`SW_NUM_PORTS-1:0] rd
);
    import switch_pkg::*;

    localparam int N = `SW_NUM_PORTS;

    page_id_t  [N-1:0] free_page;
    logic      [N-1:0] free_valid;
    logic      [N-1:0] alloc;
    bank_wr_t  [N-1:0] bank_wr;
    wr_desc_t  [N-1:0] desc;
    logic      [N-1:0] desc_valid;
    logic      [N-1:0] grant;
    pkt_desc_t [N-1:0] queue_head;
    logic      [N-1:0] queue_valid;
    logic      [N-1:0] queue_pop;
    bank_rd_t          bank_rd;
    data_t     [N-1:0] bank_rd_data;
    logic      [N-1:0] release_en;
    page_id_t          release_page;

    // ======================================================================
    // input side, each port with its own bank
    // ======================================================================
    for (genvar i = 0; i < N; i++) begin : g_port
        write_port write_port_inst (
            .clk        (clk),
            .rst_n      (rst_n),
            .wr         (wr[i]),
            .pause      (pause[i]),
            .free_page  (free_page[i]),
            .free_valid (free_valid[i]),
            .alloc      (alloc[i]),
            .bank_wr    (bank_wr[i]),
            .desc       (desc[i]),
            .desc_valid (desc_valid[i]),
            .grant      (grant[i])
        );

        packet_bank packet_bank_inst (
            .clk          (clk),
            .rst_n        (rst_n),
            .wr           (bank_wr[i]),
            .alloc        (alloc[i]),
            .free_page    (free_page[i]),
            .free_valid   (free_valid[i]),
            .rd_addr      (bank_rd),
            .rd_data      (bank_rd_data[i]),
            .release_en   (release_en[i]),
            .release_page (release_page)
        );
    end

    // ======================================================================
    // queueing and read side
    // ======================================================================
    output_queues output_queues_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .desc        (desc),
        .desc_valid  (desc_valid),
        .grant       (grant),
        .queue_pop   (queue_pop),
        .queue_head  (queue_head),
        .queue_valid (queue_valid)
    );

    read_scheduler read_scheduler_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .queue_head   (queue_head),
        .queue_valid  (queue_valid),
        .ready        (ready),
        .queue_pop    (queue_pop),
        .bank_rd      (bank_rd),
        .bank_rd_data (bank_rd_data),
        .release_en   (release_en),
        .release_page (release_page),
        .rd           (rd)
    );

endmodule

`default_nettype wire

//--- hw/sync_fifo.sv
`default_nettype none

module sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 8
) (
    input  logic clk,
    input  logic rst_n,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     head,
    output logic not_empty
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;

    assign head      = mem[rd_ptr];   // head is shown combinationally
    assign not_empty = (count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither leave the fill level alone
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/write_port.sv
`default_nettype none

module write_port (
    input  logic                 clk,
    input  logic                 rst_n,
    input  switch_pkg::wr_beat_t wr,
    output logic                 pause,
    input  switch_pkg::page_id_t free_page,
    input  logic                 free_valid,
    output logic                 alloc,
    output switch_pkg::bank_wr_t bank_wr,
    output switch_pkg::wr_desc_t desc,
    output logic                 desc_valid,
    input  logic                 grant
);
    import switch_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        STORE,
        PEND
    } state_t;

    state_t   state;
    page_id_t page_q;
    port_id_t dest_q;
    pkt_len_t word_cnt;  // next word address while storing, packet length in PEND
    logic     take;

    assign take  = (state == IDLE) && wr.vld && wr.sop && free_valid;
    assign alloc = take;  // the page is popped in the sop cycle
    assign pause = (state == PEND) || ((state == IDLE) && !free_valid);

    always_comb begin
        bank_wr.en   = take || ((state == STORE) && wr.vld);
        bank_wr.page = (state == IDLE) ? free_page : page_q;
        bank_wr.word = (state == IDLE) ? '0 : word_idx_t'(word_cnt);
        bank_wr.data = wr.data;
    end

    assign desc       = '{page: page_q, dest: dest_q, len: word_cnt};
    assign desc_valid = (state == PEND);

    // page and destination of the packet being stored
    always_ff @(posedge clk) begin
        if (take) begin
            page_q <= free_page;
            dest_q <= wr.data[$bits(port_id_t)-1:0];  // low bits of word 0 name the output
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            word_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (take) begin
                        word_cnt <= pkt_len_t'(1);
                        state    <= wr.eop ? PEND : STORE;  // a one-word packet skips STORE
                    end
                end
                STORE: begin
                    if (wr.vld) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (wr.eop) begin
                            state <= PEND;
                        end
                    end
                end
                PEND: begin
                    if (grant) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- include/switch_config.svh
`ifndef SWITCH_CONFIG_SVH
`define SWITCH_CONFIG_SVH

// switch geometry, one bank per input port
`define SW_NUM_PORTS      4
`define SW_DATA_WIDTH     16

// page memory of each bank
`define SW_PAGES_PER_BANK 8
`define SW_PAGE_WORDS     16  // one page holds the longest packet

// every page of every bank fits in one queue, so queues never overflow
`define SW_QUEUE_DEPTH    32

`endif

//--- list.f
+incdir+include
hw/switch_pkg.sv
hw/sync_fifo.sv
hw/packet_bank.sv
hw/write_port.sv
hw/output_queues.sv
hw/read_scheduler.sv
hw/switch_top.sv
testbench/switch_tb.sv

//--- testbench/switch_tb.sv
`default_nettype none

`include "switch_config.svh"

module switch_tb;
    import switch_pkg::*;

    localparam int          N          = `SW_NUM_PORTS;
    localparam int          NUM_RANDOM = 50;
    localparam logic [31:0] SEED       = 32'hcb32_5434;
    // the read side serves one packet at a time, each costs its words plus three cycles
    localparam int TIMEOUT_CYCLES = 3 * (NUM_RANDOM + 30) * (`SW_PAGE_WORDS + 3);

    logic             clk;
    logic             rst_n;
    wr_beat_t [N-1:0] wr;
    logic     [N-1:0] pause;
    logic     [N-1:0] ready;
    rd_beat_t [N-1:0] rd;

    data_t exp_words [N][N][$];  // expected words per output and per source
    int    exp_len   [N][N][$];
    int    seq_num   [N];
    logic  in_pkt    [N];
    int    cur_src   [N];
    int    cur_len   [N];
    int    beat_idx  [N];
    int    rcv_count [N];
    int    beat_count[N];
    int    rnd_len   [NUM_RANDOM];
    int    rnd_dest  [NUM_RANDOM];
    int    cycle_count;

    switch_top switch_top_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr),
        .pause (pause),
        .ready (ready),
        .rd    (rd)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout, the tests did not finish in %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // ======================================================================
    // checking and helpers
    // ======================================================================
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("FAIL t=%0t %s got 0x%0h expected 0x%0h",
                               $time, name, got, expected));
        end
    endtask

    // word 0 carries dest, source and a sequence number
    function automatic data_t packet_word(input int src, input int dest, input int num);
        return data_t'({num[11:0], src[1:0], dest[1:0]});
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_packet(input int src, input int dest, input int len);
        data_t w0;
        w0 = packet_word(src, dest, seq_num[src]);
        seq_num[src]++;
        exp_len[dest][src].push_back(len);
        for (int i = 0; i < len; i++) begin
            exp_words[dest][src].push_back(w0 + data_t'(i));
        end
        while (pause[src]) begin  // sop only goes out while pause is low
            @(posedge clk);
            #1;
        end
        for (int i = 0; i < len; i++) begin
            wr[src] = '{sop: (i == 0), eop: (i == len - 1), vld: 1'b1, data: w0 + data_t'(i)};
            @(posedge clk);
            #1;
        end
        wr[src] = '0;
    endtask

    task automatic wait_drained();
        logic busy;
        busy = 1'b1;
        while (busy) begin
            busy = 1'b0;
            for (int p = 0; p < N; p++) begin
                for (int s = 0; s < N; s++) begin
                    busy = busy || (exp_words[p][s].size() != 0);
                end
            end
            if (busy) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic wait_packets(input int p, input int target);
        while (rcv_count[p] < target) begin
            @(posedge clk);
            #1;
        end
    endtask

    // ======================================================================
    // output monitor
    // ======================================================================
    task automatic check_output(input int p);
        if (!rd[p].vld) begin
            // words of a packet are contiguous, so vld stays high from sop to eop
            check_value($sformatf("rd[%0d].vld", p), 32'(rd[p].vld), 32'(in_pkt[p]));
            check_value($sformatf("rd[%0d].sop", p), 32'(rd[p].sop), 32'd0);
            check_value($sformatf("rd[%0d].eop", p), 32'(rd[p].eop), 32'd0);
        end else begin
            check_value($sformatf("rd[%0d].sop", p), 32'(rd[p].sop), 32'(!in_pkt[p]));
            if (!in_pkt[p]) begin
                cur_src[p]  = int'(rd[p].data[3:2]);
                beat_idx[p] = 0;
                in_pkt[p]   = 1'b1;
            end
            if (exp_len[p][cur_src[p]].size() == 0 && beat_idx[p] == 0) begin
                fail_run($sformatf("output %0d sent a packet from input %0d that was never sent",
                                   p, cur_src[p]));
            end else begin
                if (beat_idx[p] == 0) begin
                    cur_len[p] = exp_len[p][cur_src[p]].pop_front();
                end
                check_value($sformatf("rd[%0d].data", p), 32'(rd[p].data),
                            32'(exp_words[p][cur_src[p]].pop_front()));
                check_value($sformatf("rd[%0d].eop", p), 32'(rd[p].eop),
                            32'(beat_idx[p] == cur_len[p] - 1));
                beat_idx[p]++;
                beat_count[p]++;
                if (rd[p].eop) begin
                    in_pkt[p] = 1'b0;
                    rcv_count[p]++;
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < N; p++) begin
                check_output(p);
            end
        end
    end

    // ======================================================================
    // directed tests
    // ======================================================================
    task automatic test_single_packet();
        int base;
        base = rcv_count[2];
        send_packet(0, 2, 5);
        wait_drained();
        check_value("packets on output 2", rcv_count[2], base + 1);
    endtask

    task automatic test_parallel_inputs();
        int base [N];
        for (int p = 0; p < N; p++) begin
            base[p] = rcv_count[p];
        end
        fork
            send_packet(0, 1, 3);
            send_packet(1, 2, 8);
            send_packet(2, 3, 16);
            send_packet(3, 0, 1);
        join
        wait_drained();
        for (int p = 0; p < N; p++) begin
            check_value($sformatf("packets on output %0d", p), rcv_count[p], base[p] + 1);
        end
    endtask

    task automatic send_list(input int src);
        for (int k = src; k < NUM_RANDOM; k += N) begin
            send_packet(src, rnd_dest[k], rnd_len[k]);
        end
    endtask

    task automatic test_random_traffic();
        int want [N];
        for (int p = 0; p < N; p++) begin
            want[p] = rcv_count[p];
        end
        for (int k = 0; k < NUM_RANDOM; k++) begin
            rnd_len[k]  = 1 + int'($urandom % `SW_PAGE_WORDS);
            rnd_dest[k] = int'($urandom % N);
            want[rnd_dest[k]]++;
        end
        fork
            send_list(0);
            send_list(1);
            send_list(2);
            send_list(3);
        join
        wait_drained();
        for (int p = 0; p < N; p++) begin
            check_value($sformatf("packets on output %0d", p), rcv_count[p], want[p]);
        end
    endtask

    task automatic test_held_output();
        int base;
        int beats;
        base     = rcv_count[1];
        beats    = beat_count[1];
        ready[1] = 1'b0;
        fork
            send_packet(0, 1, 4);
            send_packet(2, 1, 9);
            send_packet(3, 1, 2);
        join
        idle_cycles(40);
        check_value("beats on output 1 while not ready", beat_count[1], beats);
        ready[1] = 1'b1;
        wait_drained();
        check_value("packets on output 1", rcv_count[1], base + 3);
    endtask

    task automatic test_page_recycling();
        int base0;
        int base3;
        base0    = rcv_count[0];
        base3    = rcv_count[3];
        ready[3] = 1'b0;
        for (int i = 0; i < `SW_PAGES_PER_BANK; i++) begin
            send_packet(0, 3, 2 + i);  // one page each until bank 0 runs dry
        end
        idle_cycles(8);
        check_value("pause[0] with bank 0 full", 32'(pause[0]), 32'd1);
        send_packet(1, 0, 6);
        wait_packets(0, base0 + 1);
        check_value("pause[0] with bank 0 full", 32'(pause[0]), 32'd1);
        check_value("packets on output 3 while not ready", rcv_count[3], base3);
        ready[3] = 1'b1;
        while (pause[0]) begin
            @(posedge clk);
            #1;
        end
        send_packet(0, 3, 7);
        wait_drained();
        check_value("packets on output 3", rcv_count[3], base3 + `SW_PAGES_PER_BANK + 1);
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        void'($urandom(SEED));
        wr          = '0;
        ready       = '1;
        rst_n       = 1'b0;
        cycle_count = 0;
        for (int p = 0; p < N; p++) begin
            seq_num[p]    = 0;
            in_pkt[p]     = 1'b0;
            cur_src[p]    = 0;
            cur_len[p]    = 0;
            beat_idx[p]   = 0;
            rcv_count[p]  = 0;
            beat_count[p] = 0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("pause after reset", 32'(pause), 32'((1 << N) - 1));

        test_single_packet();
        test_parallel_inputs();
        test_random_traffic();
        test_held_output();
        test_page_recycling();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
